// ==== list.f ====
hw/vend_pkg.sv
hw/menu_if.sv
hw/cursor_nav.sv
hw/product_select.sv
hw/credit_ledger.sv
hw/lcd_line_builder.sv
hw/vend_top.sv
dv/vend_assertions.sv
dv/vend_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert --top-module vend_tb -f list.f -o vend_sim > build.log 2>&1 &&
    ./obj_dir/vend_sim +verilator+error+limit+1000 > sim.log 2>&1 ||
    echo "Some tests failed" >> sim.log
cat build.log sim.log
grep -q "Some tests failed" sim.log && exit 1
grep -q "All tests passed" sim.log || exit 1
exit 0

// ==== dv/vend_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vend_tb
    import vend_pkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 4;
    localparam int RET_TICKS = 4;
    localparam int IDLE_CYCLES = 2;
    localparam int SCRIPT_PULSES = 30;
    localparam int TAIL_PULSES = 40;
    localparam int SEED = 64860;
    // pulse edge, release edge, idle cycles and up to two random gaps
    localparam int PULSE_CYCLES = IDLE_CYCLES + 4;
    // room for two payouts of a saturated credit
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + (SCRIPT_PULSES + TAIL_PULSES) * PULSE_CYCLES
                                     + 2 * 256 * RET_TICKS;
    localparam logic [BTN_W-1:0] TWO_COINS = (BTN_W'(1) << BTN_COIN_SMALL)
                                             | (BTN_W'(1) << BTN_COIN_MID);

    logic clk;
    logic rst;
    logic [BTN_W-1:0] buttons;
    logic admin_mode;
    credit_t display_money_binary;
    lcd_line_t line1_text;
    lcd_line_t line2_text;
    logic [DDRAM_W-1:0] ddram_address;
    int pulses = 0;
    int failures;

    vend_top #(
        .RETURN_TICKS (RET_TICKS)
    ) dut0 (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (buttons),
        .admin_mode           (admin_mode),
        .display_money_binary (display_money_binary),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .ddram_address        (ddram_address)
    );

    bind vend_top vend_assertions #(
        .RETURN_TICKS (RETURN_TICKS)
    ) chk0 (
        .clk                  (clk),
        .rst                  (rst),
        .button_sw_oneshot    (button_sw_oneshot),
        .admin_mode           (admin_mode),
        .display_money_binary (display_money_binary),
        .line1_text           (line1_text),
        .line2_text           (line2_text),
        .ddram_address        (ddram_address)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////
    // stimulus helpers
    ////////////////////////////////////////
    // one pulse, then the buttons go quiet
    task automatic press_word(input logic [BTN_W-1:0] word);
        @(posedge clk);
        buttons <= word;
        @(posedge clk);
        buttons <= '0;
        repeat (IDLE_CYCLES) @(posedge clk);
        pulses++;
    endtask

    task automatic press(input int pos);
        logic [BTN_W-1:0] word;
        word = '0;
        word[pos] = 1'b1;
        press_word(word);
    endtask

    task automatic set_admin(input logic on);
        @(posedge clk);
        admin_mode <= on;
    endtask

    // sampled on the falling edge, away from register updates
    task automatic wait_paid_out();
        @(negedge clk);
        while (display_money_binary != '0) begin
            @(negedge clk);
        end
    endtask

    ////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////
    initial begin
        int pick;
        buttons = '0;
        rst = 1'b0;
        admin_mode = 1'b0;
        void'($urandom(SEED));
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        // coins, then a double coin that must be ignored
        press(BTN_COIN_SMALL);
        press(BTN_COIN_MID);
        press(BTN_COIN_LARGE);
        press_word(TWO_COINS);

        // buy product 1 with 16 units, stock shown in admin mode
        set_admin(1'b1);
        press(BTN_SELECT);
        press(BTN_BUY);

        // exactly the price is not enough
        repeat (4) press(BTN_COIN_SMALL);
        press(BTN_SELECT);
        press(BTN_BUY);
        press(BTN_SELECT);
        set_admin(1'b0);

        // walk the cursor to both ends and past them
        repeat (3) press(BTN_DOWN);
        press(BTN_SELECT);
        repeat (3) press(BTN_UP);

        // product 2 sells out
        press(BTN_DOWN);
        press(BTN_SELECT);
        press(BTN_COIN_LARGE);
        press(BTN_BUY);
        press(BTN_SELECT);

        // pay out the change, then a return with nothing left
        press(BTN_RETURN);
        wait_paid_out();
        press(BTN_RETURN);

        // random tail of coins and moves
        for (int i = 0; i < TAIL_PULSES; i++) begin
            pick = int'($urandom_range(5, 0));
            case (pick)
                0: press(BTN_COIN_SMALL);
                1: press(BTN_COIN_MID);
                2: press(BTN_COIN_LARGE);
                3: press(BTN_UP);
                4: press(BTN_DOWN);
                default: press_word(TWO_COINS);
            endcase
            repeat ($urandom_range(2, 0)) @(posedge clk);
        end
        press(BTN_RETURN);
        wait_paid_out();

        repeat (4) @(posedge clk);
        failures = dut0.chk0.fail_count;
        $display("run complete: %0d button pulses, %0d assertion failures", pulses, failures);
        if (failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d clock cycles, %0d failures so far",
                 WATCHDOG_CYCLES, dut0.chk0.fail_count);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/vend_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module vend_assertions
    import vend_pkg::*;
#(
    parameter int RETURN_TICKS = 4
) (
    input logic               clk,
    input logic               rst,
    input logic [BTN_W-1:0]   button_sw_oneshot,
    input logic               admin_mode,
    input credit_t            display_money_binary,
    input lcd_line_t          line1_text,
    input lcd_line_t          line2_text,
    input logic [DDRAM_W-1:0] ddram_address
);

    int fail_count = 0;

    // reference state, product ids 1..3 and 0 for none
    int m_credit;
    int m_cur;
    logic m_low;
    int m_sel;
    int m_stock [NUM_PRODUCTS];
    logic m_ret;
    int m_tick;

    logic up;
    logic down;
    logic tog;
    logic [2:0] coins;
    logic coin_ok;
    logic buy_ok;
    logic ret_p;
    logic tick;
    int coin_sum;
    int sel_price;
    int sel_stock;
    int nxt_credit;
    int win_top;
    lcd_line_t exp_line1;
    lcd_line_t exp_line2;

    // name, space, price, "00W", mark, status, arrow
    function automatic lcd_line_t line_text(
        input int    i,
        input int    sel,
        input int    cnt,
        input logic  adm,
        input char_t last
    );
        char_t mark;
        char_t status;
        mark = (sel == i + 1) ? CH_STAR : CH_SPACE;
        if (adm) begin
            status = CH_ZERO + char_t'(cnt);
        end else begin
            status = (cnt == 0) ? CH_SOLDOUT : CH_SPACE;
        end
        return {PROD_NAME[i], CH_SPACE, PRICE_TEXT[i], "00W", mark, status, last};
    endfunction

    ////////////////////////////////////////
    // button priority and next credit
    ////////////////////////////////////////
    always_comb begin
        coins = {button_sw_oneshot[BTN_COIN_SMALL], button_sw_oneshot[BTN_COIN_MID],
                 button_sw_oneshot[BTN_COIN_LARGE]};
        up = button_sw_oneshot[BTN_UP];
        down = !up && button_sw_oneshot[BTN_DOWN];
        tog = !up && !down && button_sw_oneshot[BTN_SELECT];
        coin_ok = !up && !down && !tog && $onehot(coins);
        sel_price = (m_sel != 0) ? int'(PRICE[m_sel - 1]) : 0;
        sel_stock = (m_sel != 0) ? m_stock[m_sel - 1] : 0;
        buy_ok = !up && !down && !tog && coins == 3'b000 && button_sw_oneshot[BTN_BUY]
                 && m_sel != 0 && sel_stock != 0 && m_credit > sel_price;
        ret_p = !up && !down && !tog && coins == 3'b000 && !button_sw_oneshot[BTN_BUY]
                && button_sw_oneshot[BTN_RETURN];
        tick = m_ret && !ret_p && m_tick == RETURN_TICKS - 1;
        coin_sum = m_credit;
        if (coin_ok) begin
            coin_sum = m_credit + (coins[2] ? int'(COIN_SMALL)
                                 : (coins[1] ? int'(COIN_MID) : int'(COIN_LARGE)));
        end
        nxt_credit = ((coin_sum > 255) ? 255 : coin_sum) - (buy_ok ? sel_price : 0)
                     - ((tick && m_credit != 0) ? 1 : 0);
        win_top = (m_cur == 0 || (m_cur == 1 && m_low)) ? 0 : 1;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            m_credit <= 0;
            m_cur <= 0;
            m_low <= 1'b0;
            m_sel <= 0;
            m_ret <= 1'b0;
            m_tick <= 0;
            for (int i = 0; i < NUM_PRODUCTS; i++) begin
                m_stock[i] <= int'(INIT_STOCK[i]);
            end
        end else begin
            m_credit <= nxt_credit;
            if (up && m_cur > 0) begin
                m_cur <= m_cur - 1;
                m_low <= 1'b0;
            end else if (down && m_cur < NUM_PRODUCTS - 1) begin
                m_cur <= m_cur + 1;
                m_low <= 1'b1;
            end
            if (tog) begin
                m_sel <= (m_sel == m_cur + 1) ? 0 : ((m_stock[m_cur] != 0) ? m_cur + 1 : m_sel);
            end else if (buy_ok) begin
                m_stock[m_sel - 1] <= sel_stock - 1;
                m_sel <= 0;
            end
            if (ret_p) begin
                m_ret <= 1'b1;
                m_tick <= 0;
            end else if (m_ret) begin
                m_ret <= !tick || nxt_credit != 0;
                m_tick <= tick ? 0 : m_tick + 1;
            end
        end
        // lines trail the state by one register stage
        exp_line1 <= line_text(win_top, m_sel, m_stock[win_top], admin_mode, CH_UP);
        exp_line2 <= line_text(win_top + 1, m_sel, m_stock[win_top + 1], admin_mode, CH_DOWN);
    end

    ////////////////////////////////////////
    // checks against the model
    ////////////////////////////////////////
    credit_matches: assert property (@(posedge clk) disable iff (!rst)
        display_money_binary == credit_t'(m_credit))
    else begin
        fail_count++;
        $error("ERROR t=%0t credit differs from the model", $time);
    end

    address_matches: assert property (@(posedge clk) disable iff (!rst)
        ddram_address == (m_low ? DDRAM_LINE2 : DDRAM_LINE1))
    else begin
        fail_count++;
        $error("ERROR t=%0t ddram address differs from the model", $time);
    end

    line1_matches: assert property (@(posedge clk) disable iff (!rst)
        line1_text == exp_line1)
    else begin
        fail_count++;
        $error("ERROR t=%0t line 1 text differs from the model", $time);
    end

    line2_matches: assert property (@(posedge clk) disable iff (!rst)
        line2_text == exp_line2)
    else begin
        fail_count++;
        $error("ERROR t=%0t line 2 text differs from the model", $time);
    end

endmodule

`default_nettype wire

// ==== hw/vend_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module vend_top
    import vend_pkg::*;
#(
    parameter int RETURN_TICKS = 1000000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [BTN_W-1:0]   button_sw_oneshot,
    input  logic               admin_mode,
    output credit_t            display_money_binary,
    output lcd_line_t          line1_text,
    output lcd_line_t          line2_text,
    output logic [DDRAM_W-1:0] ddram_address
);

    logic move_up;
    logic move_down;
    logic select_toggle;
    logic coin_valid;
    credit_t coin_value;
    logic buy;
    logic return_req;
    logic [2:0] coin_bits;

    logic purchase;
    credit_t purchase_price;
    credit_t credit;

    menu_if menu ();

    ////////////////////////////////////////
    // button decode
    ////////////////////////////////////////
    assign coin_bits = {button_sw_oneshot[BTN_COIN_SMALL],
                        button_sw_oneshot[BTN_COIN_MID],
                        button_sw_oneshot[BTN_COIN_LARGE]};

    // priority up > down > select > coin > buy > return
    always_comb begin
        move_up = 1'b0;
        move_down = 1'b0;
        select_toggle = 1'b0;
        coin_valid = 1'b0;
        coin_value = '0;
        buy = 1'b0;
        return_req = 1'b0;
        if (button_sw_oneshot[BTN_UP]) begin
            move_up = 1'b1;
        end else if (button_sw_oneshot[BTN_DOWN]) begin
            move_down = 1'b1;
        end else if (button_sw_oneshot[BTN_SELECT]) begin
            select_toggle = 1'b1;
        end else if (coin_bits != 3'b000) begin
            // several coins at once are ignored
            case (coin_bits)
                3'b100: begin
                    coin_valid = 1'b1;
                    coin_value = COIN_SMALL;
                end
                3'b010: begin
                    coin_valid = 1'b1;
                    coin_value = COIN_MID;
                end
                3'b001: begin
                    coin_valid = 1'b1;
                    coin_value = COIN_LARGE;
                end
                default: begin
                    coin_valid = 1'b0;
                end
            endcase
        end else if (button_sw_oneshot[BTN_BUY]) begin
            buy = 1'b1;
        end else if (button_sw_oneshot[BTN_RETURN]) begin
            return_req = 1'b1;
        end
    end

    ////////////////////////////////////////
    // blocks
    ////////////////////////////////////////
    cursor_nav nav0 (
        .clk           (clk),
        .rst           (rst),
        .move_up       (move_up),
        .move_down     (move_down),
        .ddram_address (ddram_address),
        .menu          (menu.nav)
    );

    product_select sel0 (
        .clk            (clk),
        .rst            (rst),
        .select_toggle  (select_toggle),
        .buy            (buy),
        .credit         (credit),
        .purchase       (purchase),
        .purchase_price (purchase_price),
        .menu           (menu.sel),
        .cursor_pos     (menu.cursor_pos)
    );

    credit_ledger #(
        .RETURN_TICKS (RETURN_TICKS)
    ) ledger0 (
        .clk            (clk),
        .rst            (rst),
        .coin_valid     (coin_valid),
        .coin_value     (coin_value),
        .purchase       (purchase),
        .purchase_price (purchase_price),
        .return_req     (return_req),
        .credit         (credit)
    );

    lcd_line_builder lcd0 (
        .clk        (clk),
        .rst        (rst),
        .admin_mode (admin_mode),
        .menu       (menu.view),
        .line1_text (line1_text),
        .line2_text (line2_text)
    );

    assign display_money_binary = credit;

endmodule

`default_nettype wire

// ==== hw/lcd_line_builder.sv ====
`timescale 1ns/10ps
`default_nettype none

module lcd_line_builder
    import vend_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      admin_mode,
    menu_if.view      menu,
    output lcd_line_t line1_text,
    output lcd_line_t line2_text
);

    // one product per line:
    // name(7) space price(2) "00W" mark status end
    function automatic lcd_line_t make_line(
        input int     idx,
        input logic   is_sel,
        input stock_t cnt,
        input logic   admin,
        input char_t  end_ch
    );
        char_t mark;
        char_t status;
        if (is_sel) begin
            mark = CH_STAR;
        end else begin
            mark = CH_SPACE;
        end
        if (admin) begin
            // stock as a single digit
            status = CH_ZERO + char_t'(cnt);
        end else if (cnt == '0) begin
            status = CH_SOLDOUT;
        end else begin
            status = CH_SPACE;
        end
        return {PROD_NAME[idx], CH_SPACE, PRICE_TEXT[idx], CH_ZERO, CH_ZERO, CH_W,
                mark, status, end_ch};
    endfunction

    logic [1:0] top_idx;
    logic [1:0] bot_idx;
    logic top_sel;
    logic bot_sel;

    ////////////////////////////////////////
    // window selection
    ////////////////////////////////////////
    // cursor 1 shows 1/2 when it arrived from above, else 2/3
    always_comb begin
        if (menu.cursor_pos == '0 || (menu.cursor_pos == 2'd1 && menu.line2_active)) begin
            top_idx = 2'd0;
        end else begin
            top_idx = 2'd1;
        end
        bot_idx = top_idx + 2'd1;
        top_sel = (menu.selected_item == prod_id_t'(top_idx + 2'd1));
        bot_sel = (menu.selected_item == prod_id_t'(bot_idx + 2'd1));
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            line1_text <= make_line(0, 1'b0, INIT_STOCK[0], 1'b0, CH_UP);
            line2_text <= make_line(1, 1'b0, INIT_STOCK[1], 1'b0, CH_DOWN);
        end else begin
            line1_text <= make_line(int'(top_idx), top_sel, menu.stock[top_idx],
                                    admin_mode, CH_UP);
            line2_text <= make_line(int'(bot_idx), bot_sel, menu.stock[bot_idx],
                                    admin_mode, CH_DOWN);
        end
    end

endmodule

`default_nettype wire

// ==== hw/credit_ledger.sv ====
`timescale 1ns/10ps
`default_nettype none

module credit_ledger
    import vend_pkg::*;
#(
    parameter int RETURN_TICKS = 1000000
) (
    input  logic    clk,
    input  logic    rst,
    input  logic    coin_valid,
    input  credit_t coin_value,
    input  logic    purchase,
    input  credit_t purchase_price,
    input  logic    return_req,
    output credit_t credit
);

    localparam int TICK_W = (RETURN_TICKS > 1) ? $clog2(RETURN_TICKS) : 1;
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(RETURN_TICKS - 1);
    localparam credit_t CREDIT_MAX = '1;

    credit_t credit_q;
    credit_t credit_next;
    logic [8:0] coin_sum;

    logic returning_q;
    logic [TICK_W-1:0] tick_cnt;
    logic tick;

    ////////////////////////////////////////
    // credit arithmetic
    ////////////////////////////////////////
    assign coin_sum = {1'b0, credit_q} + {1'b0, coin_value};

    // a fresh return request restarts the pacing
    assign tick = returning_q && !return_req && (tick_cnt == TICK_LAST);

    always_comb begin
        credit_next = credit_q;
        if (coin_valid) begin
            // saturate instead of wrapping
            credit_next = coin_sum[8] ? CREDIT_MAX : coin_sum[7:0];
        end
        if (purchase) begin
            credit_next = credit_next - purchase_price;
        end
        // pay out one unit per tick
        if (tick && credit_q != '0) begin
            credit_next = credit_next - 1'b1;
        end
    end

    ////////////////////////////////////////
    // change return pacing
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (!rst) begin
            credit_q <= '0;
            returning_q <= 1'b0;
            tick_cnt <= '0;
        end else begin
            credit_q <= credit_next;
            if (return_req) begin
                returning_q <= 1'b1;
                tick_cnt <= '0;
            end else if (returning_q) begin
                if (tick) begin
                    tick_cnt <= '0;
                    // done once nothing is left to pay out
                    returning_q <= (credit_next != '0);
                end else begin
                    tick_cnt <= tick_cnt + 1'b1;
                end
            end
        end
    end

    assign credit = credit_q;

endmodule

`default_nettype wire

// ==== hw/product_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module product_select
    import vend_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    select_toggle,
    input  logic    buy,
    input  credit_t credit,
    output logic    purchase,
    output credit_t purchase_price,
    menu_if.sel     menu,
    input  cursor_t cursor_pos
);

    stock_t [NUM_PRODUCTS-1:0] stock_q;
    prod_id_t sel_q;

    prod_id_t cursor_id;
    logic [1:0] sel_idx;
    credit_t sel_price;
    stock_t sel_stock;

    assign cursor_id = prod_id_t'(cursor_pos) + 2'd1;
    assign sel_idx = sel_q - 2'd1;

    // price and stock of the selected product, zero when none
    always_comb begin
        sel_price = '0;
        sel_stock = '0;
        for (int i = 0; i < NUM_PRODUCTS; i++) begin
            if (sel_q == prod_id_t'(i + 1)) begin
                sel_price = PRICE[i];
                sel_stock = stock_q[i];
            end
        end
    end

    ////////////////////////////////////////
    // purchase decision
    ////////////////////////////////////////
    // credit must be strictly above the price
    assign purchase = buy && (sel_q != '0) && (sel_stock != '0) && (credit > sel_price);
    assign purchase_price = sel_price;

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NUM_PRODUCTS; i++) begin
                stock_q[i] <= INIT_STOCK[i];
            end
            sel_q <= '0;
        end else if (select_toggle) begin
            if (sel_q == cursor_id) begin
                sel_q <= '0;
            end else if (stock_q[cursor_pos] != '0) begin
                sel_q <= cursor_id;
            end
        end else if (purchase) begin
            stock_q[sel_idx] <= stock_q[sel_idx] - 1'b1;
            sel_q <= '0;
        end
    end

    assign menu.selected_item = sel_q;
    assign menu.stock = stock_q;

endmodule

`default_nettype wire

// ==== hw/cursor_nav.sv ====
`timescale 1ns/10ps
`default_nettype none

module cursor_nav
    import vend_pkg::*;
(
    input  logic               clk,
    input  logic               rst,
    input  logic               move_up,
    input  logic               move_down,
    output logic [DDRAM_W-1:0] ddram_address,
    menu_if.nav                menu
);

    localparam cursor_t CURSOR_MAX = cursor_t'(NUM_PRODUCTS - 1);

    cursor_t cursor_q;
    logic line2_q;

    // step and saturate, the lcd line follows the direction of travel
    always_ff @(posedge clk) begin
        if (!rst) begin
            cursor_q <= '0;
            line2_q <= 1'b0;
        end else if (move_up) begin
            if (cursor_q != '0) begin
                cursor_q <= cursor_q - 1'b1;
                line2_q <= 1'b0;
            end
        end else if (move_down) begin
            if (cursor_q != CURSOR_MAX) begin
                cursor_q <= cursor_q + 1'b1;
                line2_q <= 1'b1;
            end
        end
    end

    assign ddram_address = line2_q ? DDRAM_LINE2 : DDRAM_LINE1;

    assign menu.cursor_pos = cursor_q;
    assign menu.line2_active = line2_q;

endmodule

`default_nettype wire

// ==== hw/menu_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface menu_if
    import vend_pkg::*;
();

    // cursor state
    cursor_t cursor_pos;
    logic line2_active;

    // selection and stock, bit slice 0 is product 1
    prod_id_t selected_item;
    stock_t [NUM_PRODUCTS-1:0] stock;

    modport nav (
        output cursor_pos,
        output line2_active
    );

    modport sel (
        output selected_item,
        output stock
    );

    modport view (
        input cursor_pos,
        input line2_active,
        input selected_item,
        input stock
    );

endinterface

`default_nettype wire

// ==== hw/vend_pkg.sv ====
`default_nettype none

package vend_pkg;

    ////////////////////////////////////////
    // widths and basic types
    ////////////////////////////////////////
    localparam int NUM_PRODUCTS = 3;
    localparam int BTN_W = 12;
    localparam int DDRAM_W = 7;

    // 0 means no product, 1..3 are the products
    typedef logic [1:0] prod_id_t;
    // credit in units of 100 won
    typedef logic [7:0] credit_t;
    typedef logic [3:0] stock_t;
    typedef logic [1:0] cursor_t;
    typedef logic [7:0] char_t;
    typedef logic [8*16-1:0] lcd_line_t;
    typedef logic [8*7-1:0] name_t;
    typedef logic [8*2-1:0] digits_t;

    ////////////////////////////////////////
    // product table, index 0 is product 1
    ////////////////////////////////////////
    localparam credit_t PRICE [NUM_PRODUCTS] = '{8'd10, 8'd12, 8'd15};
    localparam stock_t INIT_STOCK [NUM_PRODUCTS] = '{4'd4, 4'd1, 4'd0};
    localparam name_t PROD_NAME [NUM_PRODUCTS] = '{"1.Coke ", "2.Water", "3.Juice"};
    localparam digits_t PRICE_TEXT [NUM_PRODUCTS] = '{"10", "12", "15"};

    // coin values
    localparam credit_t COIN_SMALL = 8'd1;
    localparam credit_t COIN_MID = 8'd5;
    localparam credit_t COIN_LARGE = 8'd10;

    ////////////////////////////////////////
    // button word bit positions
    ////////////////////////////////////////
    localparam int BTN_UP = 10;
    localparam int BTN_DOWN = 4;
    localparam int BTN_SELECT = 7;
    localparam int BTN_BUY = 9;
    localparam int BTN_RETURN = 3;
    localparam int BTN_COIN_LARGE = 0;
    localparam int BTN_COIN_MID = 1;
    localparam int BTN_COIN_SMALL = 2;

    // lcd cursor sits on the selection mark column
    localparam logic [DDRAM_W-1:0] DDRAM_LINE1 = 7'h0d;
    localparam logic [DDRAM_W-1:0] DDRAM_LINE2 = 7'h4d;

    // ascii codes
    localparam char_t CH_SPACE = 8'h20;
    localparam char_t CH_STAR = 8'h2a;
    localparam char_t CH_SOLDOUT = 8'h58;
    localparam char_t CH_ZERO = 8'h30;
    localparam char_t CH_W = 8'h57;
    localparam char_t CH_UP = 8'h5e;
    localparam char_t CH_DOWN = 8'h76;

endpackage

`default_nettype wire
